// ==== verilog/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // widths of the shared memory bus
    localparam int BUS_DW   = 32;
    localparam int BUS_AW   = 30;
    localparam int BUS_SELW = 4;

    // region view of the word address
    localparam int REGION_W = 9;
    localparam int OFFSET_W = BUS_AW - REGION_W;

    // io view of the word address
    localparam int IO_IDX_W  = 6;
    localparam int IO_PAGE_W = BUS_AW - IO_IDX_W;

    // one word address read either as region/offset or as io page/index
    typedef union packed {
        struct packed {
            logic [REGION_W-1:0] region;
            logic [OFFSET_W-1:0] offset;
        } rgn;
        struct packed {
            logic [IO_PAGE_W-1:0] page;
            logic [IO_IDX_W-1:0]  index;
        } io;
    } bus_addr_u;

endpackage

`default_nettype wire

// ==== verilog/map_pkg.sv ====
`default_nettype none

package map_pkg;

    // 8 MB regions, selected by the top word address bits
    localparam logic [bus_pkg::REGION_W-1:0] REGION_RAM = 9'd0;
    localparam logic [bus_pkg::REGION_W-1:0] REGION_SYS = 9'd1;

    // io block at byte 0x0100_0000
    localparam logic [bus_pkg::IO_PAGE_W-1:0] IO_PAGE = 24'h01_0000;
    localparam logic [bus_pkg::IO_IDX_W-1:0]  IO_SW_LED = 6'd1;

    // system register indices, low offset bits
    localparam int SYS_IDX_W = 4;

    localparam logic [SYS_IDX_W-1:0] SYS_ID       = 4'd0;
    localparam logic [SYS_IDX_W-1:0] SYS_SCRATCH  = 4'd1;
    localparam logic [SYS_IDX_W-1:0] SYS_ERR_ADDR = 4'd2;
    localparam logic [SYS_IDX_W-1:0] SYS_POWER    = 4'd3;
    localparam logic [SYS_IDX_W-1:0] SYS_INT      = 4'd4;

    localparam logic [bus_pkg::BUS_DW-1:0] SYS_ID_VALUE = 32'h2019_1028;

endpackage

`default_nettype wire

// ==== verilog/wb_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface wb_bus_if;
    import bus_pkg::*;

    // request
    logic                cyc;
    logic                stb;
    logic                we;
    bus_addr_u           adr;
    logic [BUS_DW-1:0]   dat;
    logic [BUS_SELW-1:0] sel;

    // response
    logic                ack;
    logic                stall;
    logic                err;
    logic [BUS_DW-1:0]   rdat;

    modport master (output cyc, stb, we, adr, dat, sel,
                    input  ack, stall, err, rdat);

    modport slave  (input  cyc, stb, we, adr, dat, sel,
                    output ack, stall, err, rdat);

    // devices never stall and never flag errors
    modport device (input  cyc, stb, we, adr, dat, sel,
                    output ack, rdat);

endinterface

`default_nettype wire

// ==== verilog/wb_pri_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_pri_arbiter (
    input  logic     i_clk,
    input  logic     i_rst_n,
    wb_bus_if.slave  i_a,
    wb_bus_if.slave  i_b,
    wb_bus_if.master o_bus
);

    // grant from the last cycle, low means side A
    logic grant_b;
    // side B owns the merged bus this cycle
    logic owner_b;

    // B keeps the bus as long as it holds cyc
    // otherwise it only wins when A is idle
    assign owner_b = grant_b ? i_b.cyc : (i_b.cyc && !i_a.cyc);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            grant_b <= 1'b0;
        end else begin
            grant_b <= owner_b;
        end
    end

    // owner's request onto the merged bus
    assign o_bus.cyc = owner_b ? i_b.cyc : i_a.cyc;
    assign o_bus.stb = owner_b ? i_b.stb : i_a.stb;
    assign o_bus.we  = owner_b ? i_b.we  : i_a.we;
    assign o_bus.adr = owner_b ? i_b.adr : i_a.adr;
    assign o_bus.dat = owner_b ? i_b.dat : i_a.dat;
    assign o_bus.sel = owner_b ? i_b.sel : i_a.sel;

    // responses back to side A
    assign i_a.ack   = !owner_b && o_bus.ack;
    assign i_a.err   = !owner_b && o_bus.err;
    assign i_a.rdat  = owner_b ? '0 : o_bus.rdat;
    assign i_a.stall = owner_b || o_bus.stall;

    // responses back to side B
    assign i_b.ack   = owner_b && o_bus.ack;
    assign i_b.err   = owner_b && o_bus.err;
    assign i_b.rdat  = owner_b ? o_bus.rdat : '0;

    // B waits while A holds the bus
    assign i_b.stall = owner_b ? o_bus.stall : i_a.cyc;

endmodule

`default_nettype wire

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_decoder (
    input  logic                i_clk,
    input  logic                i_rst_n,
    wb_bus_if.slave             i_bus,
    wb_bus_if.master            o_ram,
    wb_bus_if.master            o_sys,
    wb_bus_if.master            o_io,
    output logic                o_err_pulse,
    output bus_pkg::bus_addr_u  o_err_addr
);
    import bus_pkg::*;
    import map_pkg::*;

    logic              ram_hit;
    logic              sys_hit;
    logic              io_hit;
    logic              none_hit;
    logic              ack_q;
    logic              err_q;
    logic [BUS_DW-1:0] rdat_q;
    bus_addr_u         err_addr_q;

    // region view for the big blocks, io view for single words
    assign ram_hit  = (i_bus.adr.rgn.region == REGION_RAM);
    assign sys_hit  = (i_bus.adr.rgn.region == REGION_SYS);
    assign io_hit   = (i_bus.adr.io.page == IO_PAGE) && (i_bus.adr.io.index == IO_SW_LED);
    assign none_hit = !(ram_hit || sys_hit || io_hit);

    // ram
    assign o_ram.cyc = i_bus.cyc;
    assign o_ram.stb = i_bus.stb && ram_hit;
    assign o_ram.we  = i_bus.we;
    assign o_ram.adr = i_bus.adr;
    assign o_ram.dat = i_bus.dat;
    assign o_ram.sel = i_bus.sel;

    // system registers
    assign o_sys.cyc = i_bus.cyc;
    assign o_sys.stb = i_bus.stb && sys_hit;
    assign o_sys.we  = i_bus.we;
    assign o_sys.adr = i_bus.adr;
    assign o_sys.dat = i_bus.dat;
    assign o_sys.sel = i_bus.sel;

    // switch/led port
    assign o_io.cyc = i_bus.cyc;
    assign o_io.stb = i_bus.stb && io_hit;
    assign o_io.we  = i_bus.we;
    assign o_io.adr = i_bus.adr;
    assign o_io.dat = i_bus.dat;
    assign o_io.sel = i_bus.sel;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= o_ram.ack || o_sys.ack || o_io.ack;
            err_q <= i_bus.stb && none_hit;
        end
    end

    // address of the strobe that missed the map
    always_ff @(posedge i_clk) begin
        if (i_bus.stb && none_hit) begin
            err_addr_q <= i_bus.adr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_ram.ack) begin
            rdat_q <= o_ram.rdat;
        end else if (o_sys.ack) begin
            rdat_q <= o_sys.rdat;
        end else if (o_io.ack) begin
            rdat_q <= o_io.rdat;
        end else begin
            rdat_q <= '0;
        end
    end

    assign i_bus.ack   = ack_q;
    assign i_bus.err   = err_q;
    assign i_bus.rdat  = rdat_q;
    assign i_bus.stall = 1'b0;

    assign o_err_pulse = err_q;
    assign o_err_addr  = err_addr_q;

endmodule

`default_nettype wire

// ==== verilog/sys_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module sys_regs (
    input  logic               i_clk,
    input  logic               i_rst_n,
    wb_bus_if.device           i_bus,
    input  logic               i_err_pulse,
    input  bus_pkg::bus_addr_u i_err_addr,
    output logic               o_soft_int
);
    import bus_pkg::*;
    import map_pkg::*;

    logic [SYS_IDX_W-1:0] reg_idx;
    logic                 wr_stb;
    logic [BUS_DW-1:0]    scratch;
    logic [BUS_DW-1:0]    power_cnt;
    bus_addr_u            err_addr;
    logic                 ack_q;
    logic [BUS_DW-1:0]    rdat_q;

    assign reg_idx = i_bus.adr.rgn.offset[SYS_IDX_W-1:0];
    assign wr_stb  = i_bus.stb && i_bus.we;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q      <= 1'b0;
            o_soft_int <= 1'b0;
            power_cnt  <= '0;
        end else begin
            ack_q <= i_bus.stb;
            if (wr_stb && (reg_idx == SYS_INT)) begin
                o_soft_int <= i_bus.dat[0];
            end
            // top bit sticks once the count reaches it
            if (!power_cnt[BUS_DW-1]) begin
                power_cnt <= power_cnt + BUS_DW'(1);
            end else begin
                power_cnt[BUS_DW-2:0] <= power_cnt[BUS_DW-2:0] + (BUS_DW-1)'(1);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_stb && (reg_idx == SYS_SCRATCH)) begin
            scratch <= i_bus.dat;
        end
        if (i_err_pulse) begin
            err_addr <= i_err_addr;
        end
    end

    always_ff @(posedge i_clk) begin
        case (reg_idx)
            SYS_ID:       rdat_q <= SYS_ID_VALUE;
            SYS_SCRATCH:  rdat_q <= scratch;
            SYS_ERR_ADDR: rdat_q <= {err_addr, 2'b00};
            SYS_POWER:    rdat_q <= power_cnt;
            SYS_INT:      rdat_q <= {{(BUS_DW-1){1'b0}}, o_soft_int};
            default:      rdat_q <= '0;
        endcase
    end

    assign i_bus.ack  = ack_q;
    assign i_bus.rdat = rdat_q;

endmodule

`default_nettype wire

// ==== verilog/wb_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_ram #(
    parameter int RAM_AW = 12
) (
    input  logic     i_clk,
    wb_bus_if.device i_bus
);
    import bus_pkg::*;

    logic [BUS_DW-1:0] mem [0:(1<<RAM_AW)-1];
    logic [RAM_AW-1:0] word_idx;
    logic [BUS_DW-1:0] rdat_q;
    logic              ack_q;

    // low offset bits pick the word, upper ones alias
    assign word_idx = i_bus.adr.rgn.offset[RAM_AW-1:0];

    always_ff @(posedge i_clk) begin
        if (i_bus.stb && i_bus.we) begin
            for (int lane = 0; lane < BUS_SELW; lane++) begin
                if (i_bus.sel[lane]) begin
                    mem[word_idx][lane*8 +: 8] <= i_bus.dat[lane*8 +: 8];
                end
            end
        end
    end

    // read word and ack one cycle after the strobe
    always_ff @(posedge i_clk) begin
        rdat_q <= mem[word_idx];
        ack_q  <= i_bus.stb;
    end

    assign i_bus.rdat = rdat_q;
    assign i_bus.ack  = ack_q;

endmodule

`default_nettype wire

// ==== verilog/switch_led_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module switch_led_port (
    input  logic        i_clk,
    input  logic        i_rst_n,
    wb_bus_if.device    i_bus,
    input  logic [15:0] i_switches,
    output logic [15:0] o_leds
);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_leds    <= '0;
            i_bus.ack <= 1'b0;
        end else begin
            i_bus.ack <= i_bus.stb;
            if (i_bus.stb && i_bus.we) begin
                o_leds <= i_bus.dat[15:0];
            end
        end
    end

    // switches high, leds low
    always_ff @(posedge i_clk) begin
        i_bus.rdat <= {i_switches, o_leds};
    end

endmodule

`default_nettype wire

// ==== verilog/soc_bus_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module soc_bus_top (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    // data port
    input  logic                           i_d_cyc,
    input  logic                           i_d_stb,
    input  logic                           i_d_we,
    input  logic [bus_pkg::BUS_AW-1:0]     i_d_adr,
    input  logic [bus_pkg::BUS_DW-1:0]     i_d_dat,
    input  logic [bus_pkg::BUS_SELW-1:0]   i_d_sel,
    output logic                           o_d_ack,
    output logic                           o_d_stall,
    output logic                           o_d_err,
    output logic [bus_pkg::BUS_DW-1:0]     o_d_rdat,
    // instruction port
    input  logic                           i_i_cyc,
    input  logic                           i_i_stb,
    input  logic                           i_i_we,
    input  logic [bus_pkg::BUS_AW-1:0]     i_i_adr,
    input  logic [bus_pkg::BUS_DW-1:0]     i_i_dat,
    input  logic [bus_pkg::BUS_SELW-1:0]   i_i_sel,
    output logic                           o_i_ack,
    output logic                           o_i_stall,
    output logic                           o_i_err,
    output logic [bus_pkg::BUS_DW-1:0]     o_i_rdat,
    // debug port
    input  logic                           i_g_cyc,
    input  logic                           i_g_stb,
    input  logic                           i_g_we,
    input  logic [bus_pkg::BUS_AW-1:0]     i_g_adr,
    input  logic [bus_pkg::BUS_DW-1:0]     i_g_dat,
    input  logic [bus_pkg::BUS_SELW-1:0]   i_g_sel,
    output logic                           o_g_ack,
    output logic                           o_g_stall,
    output logic                           o_g_err,
    output logic [bus_pkg::BUS_DW-1:0]     o_g_rdat,
    // board io
    input  logic [15:0]                    i_switches,
    output logic [15:0]                    o_leds,
    output logic                           o_soft_int
);
    import bus_pkg::*;

    logic      err_pulse;
    bus_addr_u err_addr;

    wb_bus_if dport_bus ();
    wb_bus_if iport_bus ();
    wb_bus_if inner_bus ();
    wb_bus_if dbg_bus ();
    wb_bus_if main_bus ();
    wb_bus_if ram_bus ();
    wb_bus_if sys_bus ();
    wb_bus_if io_bus ();

    // data port
    assign dport_bus.cyc = i_d_cyc;
    assign dport_bus.stb = i_d_stb;
    assign dport_bus.we  = i_d_we;
    assign dport_bus.adr = i_d_adr;
    assign dport_bus.dat = i_d_dat;
    assign dport_bus.sel = i_d_sel;
    assign o_d_ack   = dport_bus.ack;
    assign o_d_stall = dport_bus.stall;
    assign o_d_err   = dport_bus.err;
    assign o_d_rdat  = dport_bus.rdat;

    // instruction port
    assign iport_bus.cyc = i_i_cyc;
    assign iport_bus.stb = i_i_stb;
    assign iport_bus.we  = i_i_we;
    assign iport_bus.adr = i_i_adr;
    assign iport_bus.dat = i_i_dat;
    assign iport_bus.sel = i_i_sel;
    assign o_i_ack   = iport_bus.ack;
    assign o_i_stall = iport_bus.stall;
    assign o_i_err   = iport_bus.err;
    assign o_i_rdat  = iport_bus.rdat;

    // debug port
    assign dbg_bus.cyc = i_g_cyc;
    assign dbg_bus.stb = i_g_stb;
    assign dbg_bus.we  = i_g_we;
    assign dbg_bus.adr = i_g_adr;
    assign dbg_bus.dat = i_g_dat;
    assign dbg_bus.sel = i_g_sel;
    assign o_g_ack   = dbg_bus.ack;
    assign o_g_stall = dbg_bus.stall;
    assign o_g_err   = dbg_bus.err;
    assign o_g_rdat  = dbg_bus.rdat;

    // data port beats instruction port
    wb_pri_arbiter u_inner_arb (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_a     (dport_bus),
        .i_b     (iport_bus),
        .o_bus   (inner_bus)
    );

    // internal bus beats debug port
    wb_pri_arbiter u_outer_arb (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_a     (inner_bus),
        .i_b     (dbg_bus),
        .o_bus   (main_bus)
    );

    bus_decoder u_decoder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_bus       (main_bus),
        .o_ram       (ram_bus),
        .o_sys       (sys_bus),
        .o_io        (io_bus),
        .o_err_pulse (err_pulse),
        .o_err_addr  (err_addr)
    );

    sys_regs u_sys_regs (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_bus       (sys_bus),
        .i_err_pulse (err_pulse),
        .i_err_addr  (err_addr),
        .o_soft_int  (o_soft_int)
    );

    wb_ram u_ram (
        .i_clk (i_clk),
        .i_bus (ram_bus)
    );

    switch_led_port u_sw_led (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_bus      (io_bus),
        .i_switches (i_switches),
        .o_leds     (o_leds)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_bus_tasks.svh ====
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// io block at byte 0x0100_0000
localparam logic [BUS_AW-1:0] IO_WORD_BASE = 30'h0040_0000;
localparam logic [BUS_AW-1:0] SW_LED_ADDR  = IO_WORD_BASE + 30'd1;
localparam logic [BUS_AW-1:0] UNMAPPED_IO  = IO_WORD_BASE + 30'd5;

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected) begin
        $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, expected);
        error_count++;
    end
endtask

task automatic end_test(input string name, input int errs_at_start);
    test_count++;
    if (error_count == errs_at_start) begin
        $display("test %s: ok", name);
    end else begin
        $display("test %s: failed with %0d errors", name, error_count - errs_at_start);
    end
endtask

// system register word address, region 1
function automatic logic [BUS_AW-1:0] sys_addr(input logic [3:0] idx);
    return {9'd1, 17'd0, idx};
endfunction

// one transfer on a port: wait out stall, then wait for ack or err
task automatic transfer(input logic [1:0] port, input logic we,
                        input logic [BUS_AW-1:0] adr, input logic [BUS_DW-1:0] dat,
                        input logic [BUS_SELW-1:0] sel, output logic [BUS_DW-1:0] rdat,
                        output logic got_ack, output logic got_err,
                        output int latency, output int stalled);
    stalled = 0;
    latency = 0;
    @(negedge clk);
    m_cyc[port] = 1'b1;
    m_stb[port] = 1'b1;
    m_we[port]  = we;
    m_adr[port] = adr;
    m_dat[port] = dat;
    m_sel[port] = sel;
    #(SAMPLE_DELAY);
    while (s_stall[port] && stalled < XFER_LIMIT) begin
        // a stalled port must not see the owner's responses
        if (s_ack[port] || s_err[port]) begin
            $display("port %0d got a response while stalled at %0d ns", port, $time);
            error_count++;
        end
        stalled++;
        @(negedge clk);
        #(SAMPLE_DELAY);
    end
    if (s_stall[port]) begin
        $display("port %0d was never granted the bus at %0d ns", port, $time);
        error_count++;
    end
    // accepted at the coming edge
    @(negedge clk);
    m_stb[port] = 1'b0;
    latency = 1;
    #(SAMPLE_DELAY);
    while (!s_ack[port] && !s_err[port] && latency < XFER_LIMIT) begin
        @(negedge clk);
        latency++;
        #(SAMPLE_DELAY);
    end
    got_ack = s_ack[port];
    got_err = s_err[port];
    rdat    = s_rdat[port];
    if (!got_ack && !got_err) begin
        $display("port %0d got no response to address %h", port, adr);
        error_count++;
    end
    @(negedge clk);
    m_cyc[port] = 1'b0;
    m_we[port]  = 1'b0;
    #(SAMPLE_DELAY);
    if (s_ack[port] || s_err[port]) begin
        $display("port %0d got a second response to address %h", port, adr);
        error_count++;
    end
endtask

task automatic bus_write(input logic [1:0] port, input logic [BUS_AW-1:0] adr,
                         input logic [BUS_DW-1:0] dat, input logic [BUS_SELW-1:0] sel);
    logic [BUS_DW-1:0] rdat;
    logic              ack;
    logic              err;
    int                lat;
    int                stalled;
    transfer(port, 1'b1, adr, dat, sel, rdat, ack, err, lat, stalled);
    check_value("write ack", 32'(ack), 32'd1);
    check_value("write ack latency", 32'(lat), 32'd2);
endtask

task automatic bus_read(input logic [1:0] port, input logic [BUS_AW-1:0] adr,
                        output logic [BUS_DW-1:0] rdat);
    logic ack;
    logic err;
    int   lat;
    int   stalled;
    transfer(port, 1'b0, adr, 32'd0, 4'hf, rdat, ack, err, lat, stalled);
    check_value("read ack", 32'(ack), 32'd1);
    check_value("read ack latency", 32'(lat), 32'd2);
endtask

task automatic reset_values();
    int errs_at_start;
    errs_at_start = error_count;
    @(negedge clk);
    #(SAMPLE_DELAY);
    check_value("ack after reset", 32'(s_ack), 32'd0);
    check_value("err after reset", 32'(s_err), 32'd0);
    check_value("stall after reset", 32'(s_stall), 32'd0);
    check_value("o_leds", 32'(leds), 32'd0);
    check_value("o_soft_int", 32'(soft_int), 32'd0);
    end_test("reset values", errs_at_start);
endtask

task automatic ram_readback();
    logic [BUS_AW-1:0] addr [8];
    logic [BUS_DW-1:0] data [8];
    logic [BUS_DW-1:0] rd;
    logic [BUS_DW-1:0] expected;
    int                errs_at_start;
    errs_at_start = error_count;
    for (int i = 0; i < 8; i++) begin
        // low three bits keep the words apart
        addr[i] = {18'd0, 9'($urandom()), 3'(i)};
        data[i] = $urandom();
        bus_write(PORT_D, addr[i], data[i], 4'hf);
    end
    for (int i = 0; i < 8; i++) begin
        bus_read(PORT_D, addr[i], rd);
        check_value("ram word", rd, data[i]);
    end
    // only lane 2 may change
    bus_write(PORT_D, addr[3], 32'ha5a5_a5a5, 4'b0100);
    expected = {data[3][31:24], 8'ha5, data[3][15:0]};
    bus_read(PORT_D, addr[3], rd);
    check_value("ram byte lane 2", rd, expected);
    end_test("ram", errs_at_start);
endtask

task automatic sys_reg_access();
    logic [BUS_DW-1:0] rd;
    logic [BUS_DW-1:0] scratch_val;
    logic [BUS_DW-1:0] power_first;
    int                errs_at_start;
    errs_at_start = error_count;
    bus_read(PORT_G, sys_addr(4'd0), rd);
    check_value("id register", rd, 32'h2019_1028);
    scratch_val = $urandom();
    bus_write(PORT_G, sys_addr(4'd1), scratch_val, 4'hf);
    bus_read(PORT_G, sys_addr(4'd1), rd);
    check_value("scratch register", rd, scratch_val);
    bus_read(PORT_G, sys_addr(4'd3), power_first);
    repeat (10) @(negedge clk);
    bus_read(PORT_G, sys_addr(4'd3), rd);
    check_value("power counter increased", 32'(rd > power_first), 32'd1);
    bus_write(PORT_G, sys_addr(4'd4), 32'd1, 4'hf);
    check_value("o_soft_int", 32'(soft_int), 32'd1);
    bus_read(PORT_G, sys_addr(4'd4), rd);
    check_value("interrupt register", rd, 32'd1);
    bus_write(PORT_G, sys_addr(4'd4), 32'd0, 4'hf);
    check_value("o_soft_int", 32'(soft_int), 32'd0);
    end_test("system registers", errs_at_start);
endtask

task automatic unmapped_error();
    logic [BUS_DW-1:0] rd;
    logic              ack;
    logic              err;
    int                lat;
    int                stalled;
    int                errs_at_start;
    errs_at_start = error_count;
    transfer(PORT_D, 1'b0, UNMAPPED_IO, 32'd0, 4'hf, rd, ack, err, lat, stalled);
    check_value("err", 32'(err), 32'd1);
    check_value("ack with err", 32'(ack), 32'd0);
    check_value("err latency", 32'(lat), 32'd1);
    // byte address of io index 5
    bus_read(PORT_D, sys_addr(4'd2), rd);
    check_value("error address register", rd, 32'h0100_0014);
    end_test("bus error", errs_at_start);
endtask

task automatic switch_led_io();
    logic [BUS_DW-1:0] rd;
    logic [15:0]       led_val;
    int                errs_at_start;
    errs_at_start = error_count;
    led_val = 16'($urandom());
    @(negedge clk);
    switches = 16'($urandom());
    // upper data bits do not reach the leds
    bus_write(PORT_D, SW_LED_ADDR, {16'hdead, led_val}, 4'hf);
    check_value("o_leds", 32'(leds), 32'(led_val));
    bus_read(PORT_D, SW_LED_ADDR, rd);
    check_value("switch/led readback", rd, {switches, led_val});
    end_test("switch/led", errs_at_start);
endtask

task automatic arbitration_order();
    logic [BUS_DW-1:0] d_word;
    logic [BUS_DW-1:0] i_word;
    logic [BUS_DW-1:0] d_rd;
    logic [BUS_DW-1:0] i_rd;
    logic [BUS_DW-1:0] g_rd;
    logic              d_ack;
    logic              i_ack;
    logic              g_ack;
    logic              d_err;
    logic              i_err;
    logic              g_err;
    int                d_lat;
    int                i_lat;
    int                g_lat;
    int                d_wait;
    int                i_wait;
    int                g_wait;
    int                errs_at_start;
    errs_at_start = error_count;
    d_word = $urandom();
    i_word = $urandom();
    bus_write(PORT_D, 30'h0000_0a10, d_word, 4'hf);
    bus_write(PORT_D, 30'h0000_0a20, i_word, 4'hf);
    fork
        transfer(PORT_D, 1'b0, 30'h0000_0a10, 32'd0, 4'hf, d_rd, d_ack, d_err, d_lat, d_wait);
        transfer(PORT_I, 1'b0, 30'h0000_0a20, 32'd0, 4'hf, i_rd, i_ack, i_err, i_lat, i_wait);
        begin
            // debug asks one cycle later, while the inner bus holds cyc
            @(negedge clk);
            transfer(PORT_G, 1'b0, sys_addr(4'd0), 32'd0, 4'hf,
                     g_rd, g_ack, g_err, g_lat, g_wait);
        end
    join
    // data port drops cyc 3 cycles in, instruction port 3 cycles later
    check_value("data port stall cycles", 32'(d_wait), 32'd0);
    check_value("instruction port stall cycles", 32'(i_wait), 32'd3);
    check_value("debug port stall cycles", 32'(g_wait), 32'd5);
    check_value("data port ack", 32'(d_ack), 32'd1);
    check_value("instruction port ack", 32'(i_ack), 32'd1);
    check_value("debug port ack", 32'(g_ack), 32'd1);
    check_value("data port ack latency", 32'(d_lat), 32'd2);
    check_value("instruction port ack latency", 32'(i_lat), 32'd2);
    check_value("debug port ack latency", 32'(g_lat), 32'd2);
    check_value("data port rdat", d_rd, d_word);
    check_value("instruction port rdat", i_rd, i_word);
    check_value("debug port rdat", g_rd, 32'h2019_1028);
    end_test("arbitration", errs_at_start);
endtask

task automatic pipelined_reads();
    logic [BUS_AW-1:0] base;
    logic [BUS_DW-1:0] words [4];
    int                ack_step [$];
    logic [BUS_DW-1:0] ack_data [$];
    int                step;
    int                errs_at_start;
    errs_at_start = error_count;
    base = 30'h0000_07f0;
    for (int k = 0; k < 4; k++) begin
        words[k] = $urandom();
        bus_write(PORT_I, base + 30'(k), words[k], 4'hf);
    end
    // one strobe per cycle, acks collected as they come
    step = 0;
    while (ack_step.size() < 4 && step < XFER_LIMIT) begin
        @(negedge clk);
        if (step < 4) begin
            m_cyc[PORT_I] = 1'b1;
            m_stb[PORT_I] = 1'b1;
            m_we[PORT_I]  = 1'b0;
            m_adr[PORT_I] = base + 30'(step);
        end else begin
            m_stb[PORT_I] = 1'b0;
        end
        #(SAMPLE_DELAY);
        if (step < 4 && s_stall[PORT_I]) begin
            $display("instruction port stalled inside the burst at %0d ns", $time);
            error_count++;
        end
        if (s_ack[PORT_I]) begin
            ack_step.push_back(step);
            ack_data.push_back(s_rdat[PORT_I]);
        end
        step++;
    end
    @(negedge clk);
    m_stb[PORT_I] = 1'b0;
    m_cyc[PORT_I] = 1'b0;
    if (ack_step.size() != 4) begin
        $display("burst got %0d of 4 acks", ack_step.size());
        error_count++;
    end
    for (int k = 0; k < ack_step.size(); k++) begin
        check_value("burst ack cycle", 32'(ack_step[k]), 32'(k + 2));
        check_value("burst rdat", ack_data[k], words[k]);
    end
    end_test("pipelining", errs_at_start);
endtask

`endif

// ==== testbench/tb_soc_bus.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_soc_bus;
    import bus_pkg::*;

    localparam int CLK_PERIOD   = 20;
    // just before the rising edge, when the bus is stable
    localparam int SAMPLE_DELAY = CLK_PERIOD / 2 - 1;
    // seven tests of well under 200 cycles each, plus margin
    localparam int MAX_CYCLES   = 2000;
    localparam int XFER_LIMIT   = 50;
    localparam logic [31:0] SEED = 32'h7c41_73e2;

    // master port numbers
    localparam logic [1:0] PORT_D = 2'd0;
    localparam logic [1:0] PORT_I = 2'd1;
    localparam logic [1:0] PORT_G = 2'd2;

    logic clk = 1'b0;
    logic rst_n;

    // requests, one entry per master port
    logic [2:0]                m_cyc;
    logic [2:0]                m_stb;
    logic [2:0]                m_we;
    logic [2:0][BUS_AW-1:0]    m_adr;
    logic [2:0][BUS_DW-1:0]    m_dat;
    logic [2:0][BUS_SELW-1:0]  m_sel;

    // responses, one entry per master port
    logic [2:0]                s_ack;
    logic [2:0]                s_stall;
    logic [2:0]                s_err;
    logic [2:0][BUS_DW-1:0]    s_rdat;

    logic [15:0] switches;
    logic [15:0] leds;
    logic        soft_int;
    logic [31:0] rnd_init;

    int error_count = 0;
    int test_count  = 0;
    int cycle_count = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    soc_bus_top u_soc_bus_top (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_d_cyc    (m_cyc[0]),
        .i_d_stb    (m_stb[0]),
        .i_d_we     (m_we[0]),
        .i_d_adr    (m_adr[0]),
        .i_d_dat    (m_dat[0]),
        .i_d_sel    (m_sel[0]),
        .o_d_ack    (s_ack[0]),
        .o_d_stall  (s_stall[0]),
        .o_d_err    (s_err[0]),
        .o_d_rdat   (s_rdat[0]),
        .i_i_cyc    (m_cyc[1]),
        .i_i_stb    (m_stb[1]),
        .i_i_we     (m_we[1]),
        .i_i_adr    (m_adr[1]),
        .i_i_dat    (m_dat[1]),
        .i_i_sel    (m_sel[1]),
        .o_i_ack    (s_ack[1]),
        .o_i_stall  (s_stall[1]),
        .o_i_err    (s_err[1]),
        .o_i_rdat   (s_rdat[1]),
        .i_g_cyc    (m_cyc[2]),
        .i_g_stb    (m_stb[2]),
        .i_g_we     (m_we[2]),
        .i_g_adr    (m_adr[2]),
        .i_g_dat    (m_dat[2]),
        .i_g_sel    (m_sel[2]),
        .o_g_ack    (s_ack[2]),
        .o_g_stall  (s_stall[2]),
        .o_g_err    (s_err[2]),
        .o_g_rdat   (s_rdat[2]),
        .i_switches (switches),
        .o_leds     (leds),
        .o_soft_int (soft_int)
    );

    `include "tb_bus_tasks.svh"

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        rnd_init = $urandom(SEED);
        rst_n    = 1'b0;
        m_cyc    = '0;
        m_stb    = '0;
        m_we     = '0;
        m_adr    = '0;
        m_dat    = '0;
        m_sel    = '0;
        switches = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        ram_readback();
        sys_reg_access();
        unmapped_error();
        switch_led_io();
        arbitration_order();
        pipelined_reads();

        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+testbench
verilog/bus_pkg.sv
verilog/map_pkg.sv
verilog/wb_bus_if.sv
verilog/wb_pri_arbiter.sv
verilog/bus_decoder.sv
verilog/sys_regs.sv
verilog/wb_ram.sv
verilog/switch_led_port.sv
verilog/soc_bus_top.sv
testbench/tb_soc_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the soc bus testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module tb_soc_bus -o tb_soc_bus
./obj_dir/tb_soc_bus | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"
